// ==== common/aes_defines.svh ====
//--------------------------------------------------------------------------
// AES-128 core constants
// Block width, round count and round pipeline timing
//--------------------------------------------------------------------------
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

`define AES_BLOCK_W 128 // Block and key width in bits
`define AES_NUM_ROUNDS 10 // AES-128 round count

// Registered stages in one pass through the round pipeline
`define AES_ROUND_STAGES 4

// Edges from the start sample to the done edge
`define AES_LATENCY (`AES_NUM_ROUNDS * `AES_ROUND_STAGES + 1)

`endif

// ==== common/aes_pkg.sv ====
//--------------------------------------------------------------------------
// AES-128 shared types and GF(2^8) helper
//--------------------------------------------------------------------------
`include "aes_defines.svh"

package aes_pkg;

	typedef logic [`AES_BLOCK_W-1:0] aes_block_t; // State or key
	typedef logic [31:0] aes_word_t; // One column
	typedef logic [7:0] aes_byte_t;
	typedef logic [3:0] round_num_t;

	typedef enum logic [1:0] {IDLE, LOAD, RUN} ctrl_state_t;

	typedef struct packed {
		aes_block_t block;
		aes_block_t key;
	} aes_req_t;

	typedef struct packed {
		aes_block_t data;
		logic last; // Skip MixColumns
	} round_req_t;

	// Multiply by x in GF(2^8), reduction polynomial 0x11b
	function automatic aes_byte_t xtime(input aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

// ==== verilog/aes_sbox.sv ====
//--------------------------------------------------------------------------
// AES forward S-box, one byte per lookup
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aes_sbox (
	input aes_pkg::aes_byte_t in,
	output aes_pkg::aes_byte_t out
);
	import aes_pkg::*;

	aes_block_t row; // Sixteen entries selected by the high nibble

	always_comb
	begin
		case (in[7:4])
			4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
			4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
			4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
			4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
			4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
			4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
			4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
			4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
			4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
			4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
			4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
			4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
			4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
			4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
			4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
			default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
		endcase
	end

	// Low nibble picks the byte, entry 0 sits in the top byte
	assign out = row[8*(15 - in[3:0]) +: 8];

endmodule

// ==== round/round_transform.sv ====
//--------------------------------------------------------------------------
// AES round pipeline
// ShiftRows, SubBytes, MixColumns (bypassed on the last round), AddRoundKey
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module round_transform (
	input logic round_clk,
	input logic round_rst_n,
	input logic issue,
	input aes_pkg::round_req_t round_req,
	input aes_pkg::aes_block_t round_key,
	output logic out_valid,
	output aes_pkg::aes_block_t out_data
);
	import aes_pkg::*;

	round_req_t s1_q; // After ShiftRows
	round_req_t s2_q; // After SubBytes
	round_req_t s3_q; // After MixColumns or bypass
	logic v1_q;
	logic v2_q;
	logic v3_q;
	logic v4_q;
	aes_block_t s4_q;
	aes_block_t sub_out;

	// Byte i of the state lives at [127-8i -: 8], column c holds bytes 4c..4c+3
	function automatic aes_block_t shift_rows(input aes_block_t s);
		aes_block_t res;
		for (int c = 0; c < 4; c++)
			for (int row = 0; row < 4; row++)
				res[127-8*(4*c+row) -: 8] = s[127-8*(4*((c+row)%4)+row) -: 8];
		return res;
	endfunction

	function automatic aes_word_t mix_column(input aes_word_t col);
		aes_byte_t a0;
		aes_byte_t a1;
		aes_byte_t a2;
		aes_byte_t a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	function automatic aes_block_t mix_columns(input aes_block_t s);
		aes_block_t res;
		for (int c = 0; c < 4; c++)
			res[127-32*c -: 32] = mix_column(s[127-32*c -: 32]);
		return res;
	endfunction

	//--------------------------------------------------------------------------
	// SubBytes, one S-box per byte, grouped by column
	//--------------------------------------------------------------------------
	for (genvar c = 0; c < 4; c++)
	begin : g_col
		for (genvar b = 0; b < 4; b++)
		begin : g_byte
			aes_sbox u_sbox (
				.in (s1_q.data[127-8*(4*c+b) -: 8]),
				.out (sub_out[127-8*(4*c+b) -: 8])
			);
		end
	end

	// Stage valid bits
	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
		begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
			v3_q <= 1'b0;
			v4_q <= 1'b0;
		end
		else
		begin
			v1_q <= issue;
			v2_q <= v1_q;
			v3_q <= v2_q;
			v4_q <= v3_q;
		end
	end

	//--------------------------------------------------------------------------
	// Stage data, loaded only when the stage ahead holds a valid round
	//--------------------------------------------------------------------------
	always_ff @(posedge round_clk)
	begin
		if (issue)
		begin
			s1_q.data <= shift_rows(round_req.data);
			s1_q.last <= round_req.last;
		end
		if (v1_q)
		begin
			s2_q.data <= sub_out;
			s2_q.last <= s1_q.last;
		end
		if (v2_q)
		begin
			s3_q.data <= s2_q.last ? s2_q.data : mix_columns(s2_q.data); // Round 10 bypass
			s3_q.last <= s2_q.last;
		end
		if (v3_q)
			s4_q <= s3_q.data ^ round_key; // Key held until the next issue
	end

	assign out_valid = v4_q;
	assign out_data = s4_q;

endmodule

// ==== round/key_schedule.sv ====
//--------------------------------------------------------------------------
// AES-128 key expansion, one round key per advance
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module key_schedule (
	input logic round_clk,
	input logic round_rst_n,
	input logic start_load,
	input aes_pkg::aes_block_t cipher_key,
	input logic advance,
	output aes_pkg::aes_block_t round_key
);
	import aes_pkg::*;

	aes_block_t key_q;
	aes_byte_t rcon_q;
	aes_word_t rot_word;
	aes_word_t sub_word;
	aes_word_t temp;
	aes_word_t w0;
	aes_word_t w1;
	aes_word_t w2;
	aes_word_t w3;

	// RotWord on the last word of the current key
	assign rot_word = {key_q[23:0], key_q[31:24]};

	// SubWord
	for (genvar i = 0; i < 4; i++)
	begin : g_sub
		aes_sbox u_sbox (
			.in (rot_word[31-8*i -: 8]),
			.out (sub_word[31-8*i -: 8])
		);
	end

	always_comb
	begin
		temp = sub_word ^ {rcon_q, 24'h000000};
		w0 = key_q[127:96] ^ temp;
		w1 = key_q[95:64] ^ w0; // XOR chain across the words
		w2 = key_q[63:32] ^ w1;
		w3 = key_q[31:0] ^ w2;
	end

	// Round constant runs 01, 02, 04 .. 1b, 36
	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
			rcon_q <= 8'h01;
		else if (start_load)
			rcon_q <= 8'h01;
		else if (advance)
			rcon_q <= xtime(rcon_q);
	end

	always_ff @(posedge round_clk)
	begin
		if (start_load)
			key_q <= cipher_key;
		else if (advance)
			key_q <= {w0, w1, w2, w3};
	end

	assign round_key = key_q;

endmodule

// ==== control/round_counter.sv ====
//--------------------------------------------------------------------------
// Issued round counter with final round flag
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "aes_defines.svh"

module round_counter (
	input logic round_clk,
	input logic round_rst_n,
	input logic clear,
	input logic count_en,
	output aes_pkg::round_num_t round_num,
	output logic last_round
);
	import aes_pkg::*;

	round_num_t count_q; // Rounds issued so far

	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
			count_q <= '0;
		else if (clear)
			count_q <= '0;
		else if (count_en)
			count_q <= count_q + round_num_t'(1);
	end

	assign round_num = count_q;

	// Next round to go out is the final one
	assign last_round = (count_q == round_num_t'(`AES_NUM_ROUNDS - 1));

endmodule

// ==== control/round_ctrl_fsm.sv ====
//--------------------------------------------------------------------------
// AES core controller
// Initial key addition, round issue, result capture and done pulse
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module round_ctrl_fsm (
	input logic round_clk,
	input logic round_rst_n,
	input logic start,
	input aes_pkg::aes_req_t req,
	input logic last_round,
	input logic out_valid,
	input aes_pkg::aes_block_t out_data,
	output logic issue,
	output aes_pkg::round_req_t round_req,
	output logic start_load,
	output logic busy,
	output logic done,
	output aes_pkg::aes_block_t result
);
	import aes_pkg::*;

	ctrl_state_t state_q;
	aes_block_t load_q; // Plaintext after the initial AddRoundKey
	aes_block_t result_q;
	logic last_issued_q; // Last flag of the round in flight
	logic done_q;

	assign start_load = (state_q == IDLE) && start;

	// Next round leaves together with the previous round's output
	assign issue = (state_q == LOAD) || ((state_q == RUN) && out_valid && !last_issued_q);
	assign round_req.data = (state_q == LOAD) ? load_q : out_data;
	assign round_req.last = last_round;

	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
		begin
			state_q <= IDLE;
			last_issued_q <= 1'b0;
			done_q <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (issue)
				last_issued_q <= last_round;
			case (state_q)
				IDLE:
					if (start)
						state_q <= LOAD;
				LOAD:
					state_q <= RUN;
				RUN:
					if (out_valid && last_issued_q)
					begin
						result_q <= out_data;
						done_q <= 1'b1;
						state_q <= IDLE;
					end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge round_clk)
	begin
		if (start_load)
			load_q <= req.block ^ req.key;
	end

	assign busy = (state_q != IDLE);
	assign done = done_q;
	assign result = result_q;

endmodule

// ==== verilog/aes_core.sv ====
//--------------------------------------------------------------------------
// AES-128 encryption core top level
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aes_core (
	input logic round_clk,
	input logic round_rst_n,
	input logic start,
	input aes_pkg::aes_req_t req,
	output logic busy,
	output logic done,
	output aes_pkg::aes_block_t result
);
	import aes_pkg::*;

	logic start_load;
	logic issue;
	logic last_round;
	logic out_valid;
	round_req_t round_req;
	aes_block_t out_data;
	aes_block_t round_key;

	round_ctrl_fsm u_ctrl (
		.round_clk (round_clk),
		.round_rst_n (round_rst_n),
		.start (start),
		.req (req),
		.last_round (last_round),
		.out_valid (out_valid),
		.out_data (out_data),
		.issue (issue),
		.round_req (round_req),
		.start_load (start_load),
		.busy (busy),
		.done (done),
		.result (result)
	);

	// Round index is kept for debug only
	round_counter u_counter (
		.round_clk (round_clk),
		.round_rst_n (round_rst_n),
		.clear (start_load),
		.count_en (issue),
		.round_num (),
		.last_round (last_round)
	);

	key_schedule u_key (
		.round_clk (round_clk),
		.round_rst_n (round_rst_n),
		.start_load (start_load),
		.cipher_key (req.key),
		.advance (issue), // One key step per issued round
		.round_key (round_key)
	);

	round_transform u_round (
		.round_clk (round_clk),
		.round_rst_n (round_rst_n),
		.issue (issue),
		.round_req (round_req),
		.round_key (round_key),
		.out_valid (out_valid),
		.out_data (out_data)
	);

endmodule

// ==== dv/aes_core_chk.sv ====
//--------------------------------------------------------------------------
// AES-128 core protocol checks
// Reset state, start to done latency and done strobe rules
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_core_chk (
	input logic round_clk,
	input logic round_rst_n,
	input logic start,
	input logic busy,
	input logic done,
	input aes_pkg::aes_block_t result
);

	// Outputs cleared by reset
	reset_state: assert property (@(posedge round_clk)
		!round_rst_n |=> (!busy && !done && result == '0))
		else $error("outputs not cleared by reset");

	// Accepted start gives done after the fixed latency
	start_latency: assert property (@(posedge round_clk) disable iff (!round_rst_n)
		(start && !busy) |=> ##(`AES_LATENCY) done)
		else $error("done missing at the expected latency");

	done_pulse: assert property (@(posedge round_clk) disable iff (!round_rst_n)
		done |=> !done)
		else $error("done held longer than one cycle");

	done_idle: assert property (@(posedge round_clk) disable iff (!round_rst_n)
		done |-> !busy)
		else $error("busy high while done is high");

	// Result only moves together with a new done
	result_hold: assert property (@(posedge round_clk) disable iff (!round_rst_n)
		!$stable(result) |-> $rose(done))
		else $error("result changed without done");

endmodule

bind aes_core aes_core_chk u_chk (
	.round_clk (round_clk),
	.round_rst_n (round_rst_n),
	.start (start),
	.busy (busy),
	.done (done),
	.result (result)
);

// ==== dv/aes_core_tb.sv ====
//--------------------------------------------------------------------------
// AES-128 core testbench
// Known-answer vectors with random idle gaps and starts driven while busy
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_core_tb;
	import aes_pkg::*;

	localparam int num_req = 9;
	localparam int watchdog_cycles = num_req * (`AES_LATENCY + 8) + 50;

	// FIPS-197 Appendix C.1, Appendix B and the all-zero case
	localparam aes_block_t vec_key [3] = '{
		128'h000102030405060708090a0b0c0d0e0f,
		128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'h00000000000000000000000000000000};
	localparam aes_block_t vec_pt [3] = '{
		128'h00112233445566778899aabbccddeeff,
		128'h3243f6a8885a308d313198a2e0370734,
		128'h00000000000000000000000000000000};
	localparam aes_block_t vec_ct [3] = '{
		128'h69c4e0d86a7b0430d8cdb78070b4c55a,
		128'h3925841d02dc09fbdc118597196a0b32,
		128'h66e94bd4ef8a2c3b884cfa59ca342b2e};

	logic round_clk;
	logic round_rst_n;
	logic start;
	aes_req_t req;
	logic busy;
	logic done;
	aes_block_t result;

	logic [31:0] rng; // LCG state
	aes_block_t exp_q[$]; // Expected ciphertext per accepted start
	int start_cycle_q[$];
	int cycle_count;
	int checked;
	int gap;
	bit seen_start;
	bit passed;
	bit fail_printed;
	aes_block_t expected;
	int t0;

	aes_core UUT (
		.round_clk (round_clk),
		.round_rst_n (round_rst_n),
		.start (start),
		.req (req),
		.busy (busy),
		.done (done),
		.result (result)
	);

	initial
		round_clk = 1'b0;

	always #5 round_clk = ~round_clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_block(output aes_block_t b);
		for (int i = 0; i < 4; i++)
		begin
			rng = lcg_step(rng);
			b[32*i +: 32] = rng;
		end
	endtask

	task automatic wait_cycle();
		@(posedge round_clk);
		#1; // Drive just after the edge
	endtask

	task automatic fail_run(input string msg);
		fail_printed = 1'b1;
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped on error");
	endtask

	//--------------------------------------------------------------------------
	// Monitor sampled at the falling edge where outputs are settled
	//--------------------------------------------------------------------------
	always @(negedge round_clk)
	begin
		if (round_rst_n)
		begin
			cycle_count++;
			if (!seen_start)
				assert (!busy && !done && result == '0)
				else fail_run($sformatf("[ERROR] %0t: outputs not idle before first start", $time));
			if (done)
			begin
				assert (exp_q.size() > 0 && start_cycle_q.size() > 0)
				else fail_run($sformatf("[ERROR] %0t: done without an accepted start", $time));
				expected = exp_q.pop_front();
				t0 = start_cycle_q.pop_front();
				assert (result == expected)
				else fail_run($sformatf("[ERROR] %0t: result %h, expected %h", $time, result, expected));
				assert (cycle_count - t0 == `AES_LATENCY)
				else fail_run($sformatf("[ERROR] %0t: latency %0d, expected %0d", $time,
					cycle_count - t0, `AES_LATENCY));
				checked++;
			end
			if (start && !busy) // Taken at the next rising edge
			begin
				seen_start = 1'b1;
				start_cycle_q.push_back(cycle_count + 1); // Count of the sampling edge
			end
		end
	end

	// Watchdog
	initial
	begin
		repeat (watchdog_cycles) @(posedge round_clk);
		fail_run("Timeout: the core did not finish all requests in time");
	end

	//--------------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------------
	initial
	begin
		round_rst_n = 1'b0;
		start = 1'b0;
		req = '0;
		rng = 32'd92;
		cycle_count = 0;
		checked = 0;
		seen_start = 1'b0;
		passed = 1'b0;
		fail_printed = 1'b0;
		repeat (4) @(posedge round_clk);
		#1 round_rst_n = 1'b1;
		repeat (3) wait_cycle(); // Quiet window after reset

		for (int n = 0; n < num_req; n++)
		begin
			req.block = vec_pt[n % 3];
			req.key = vec_key[n % 3];
			start = 1'b1;
			exp_q.push_back(vec_ct[n % 3]);
			wait_cycle();
			start = 1'b0;
			while (!done)
			begin
				rng = lcg_step(rng);
				if (rng[21:20] == 2'b00)
				begin
					start = 1'b1; // Must be ignored while busy
					draw_block(req.block);
					draw_block(req.key);
				end
				else
					start = 1'b0;
				wait_cycle();
			end
			start = 1'b0;
			rng = lcg_step(rng);
			gap = (n % 3 == 1) ? 0 : int'(rng[18:16]); // Gap 0 starts in the done cycle
			repeat (gap) wait_cycle();
		end

		repeat (2) wait_cycle();
		if (checked == num_req && exp_q.size() == 0)
		begin
			passed = 1'b1;
			$display("PASS: all tests");
			$finish;
		end
		else
			fail_run($sformatf("Only %0d of %0d requests produced a result", checked, num_req));
	end

	final
	begin
		if (!passed && !fail_printed)
			$display("FAIL: see errors above");
	end

endmodule

// ==== src.f ====
+incdir+common
common/aes_pkg.sv
verilog/aes_sbox.sv
round/round_transform.sv
round/key_schedule.sv
control/round_counter.sv
control/round_ctrl_fsm.sv
verilog/aes_core.sv
dv/aes_core_chk.sv
dv/aes_core_tb.sv

// ==== Makefile ====
# Verilator build for the AES-128 core testbench

TOP       ?= aes_core_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

FAIL_MSG := FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f src.f

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
